// File: Makefile
# Verilator flow for the debug module testbench

VERILATOR ?= verilator
FILELIST  ?= compile.f
TOP       ?= tb_dm_obi_top
BUILD_DIR ?= obj_dir
VFLAGS    ?= --timing --assert
PASS_TEXT ?= Result: PASSED

.PHONY: all lint sim clean

all: sim

lint:
	$(VERILATOR) --lint-only $(VFLAGS) -f $(FILELIST) --top-module $(TOP)

$(BUILD_DIR)/V$(TOP): $(FILELIST) $(shell cat $(FILELIST))
	$(VERILATOR) --binary $(VFLAGS) -f $(FILELIST) --top-module $(TOP) \
		--Mdir $(BUILD_DIR)

sim: $(BUILD_DIR)/V$(TOP)
	@out="$$(./$(BUILD_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_TEXT)"

clean:
	rm -rf $(BUILD_DIR)

// File: compile.f
src/dm_ot.sv
src/dm_mem_pkg.sv
src/dm_dmi_regs.sv
src/dm_hart_port.sv
src/dm_state.sv
src/dm_top.sv
src/dm_obi_top.sv
sim/tb_dm_obi_top.sv

// File: sim/tb_dm_obi_top.sv
// Testbench for dm_obi_top with DmBaseAddress 0x1000 and 4-bit ids; aborts after 4000 cycles
`timescale 1ns/1ps
`default_nettype none

module tb_dm_obi_top;

  localparam int unsigned IdWidth = 4;
  localparam logic [31:0] Base = 32'h0000_1000;
  // Five short tests need well under a thousand cycles
  localparam int unsigned MaxCycles = 4000;

  logic                   clk_i;
  logic                   rst_ni;
  logic                   slave_req_i;
  logic                   slave_gnt_o;
  logic                   slave_we_i;
  logic [31:0]            slave_addr_i;
  logic [3:0]             slave_be_i;
  logic [31:0]            slave_wdata_i;
  logic [IdWidth-1:0]     slave_aid_i;
  logic                   slave_rvalid_o;
  logic [31:0]            slave_rdata_o;
  logic [IdWidth-1:0]     slave_rid_o;
  logic                   dmi_req_valid_i;
  logic                   dmi_req_ready_o;
  dm_ot::dmi_req_t        dmi_req_i;
  logic                   dmi_resp_valid_o;
  logic                   dmi_resp_ready_i;
  dm_ot::dmi_resp_t       dmi_resp_o;
  logic                   debug_req_o;
  logic                   ndmreset_o;
  logic                   dmactive_o;

  int                     seed = 32'h2ff062a0;
  int                     errors = 0;
  int                     tests_run = 0;
  int                     test_start_errors = 0;
  int                     cycles = 0;
  int                     dmi_issued = 0;
  int                     dmi_received = 0;
  // Random ready stalls on the response channel
  logic                   stall_mode = 1'b0;

  // Scoreboards: expected DMI data, expected OBI id and data
  logic [31:0]            dmi_exp_q[$];
  logic [IdWidth-1:0]     rid_exp_q[$];
  logic [31:0]            rdata_exp_q[$];
  logic [31:0]            dmi_exp;

  // Values written over DMI and read back later
  logic [31:0]            data0_val;
  logic [31:0]            prog0_val;
  logic [31:0]            prog1_val;

  dm_obi_top #(
    .IdWidth       ( IdWidth ),
    .DmBaseAddress ( Base    )
  ) uut (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .slave_req_i      ( slave_req_i      ),
    .slave_gnt_o      ( slave_gnt_o      ),
    .slave_we_i       ( slave_we_i       ),
    .slave_addr_i     ( slave_addr_i     ),
    .slave_be_i       ( slave_be_i       ),
    .slave_wdata_i    ( slave_wdata_i    ),
    .slave_aid_i      ( slave_aid_i      ),
    .slave_rvalid_o   ( slave_rvalid_o   ),
    .slave_rdata_o    ( slave_rdata_o    ),
    .slave_rid_o      ( slave_rid_o      ),
    .dmi_req_valid_i  ( dmi_req_valid_i  ),
    .dmi_req_ready_o  ( dmi_req_ready_o  ),
    .dmi_req_i        ( dmi_req_i        ),
    .dmi_resp_valid_o ( dmi_resp_valid_o ),
    .dmi_resp_ready_i ( dmi_resp_ready_i ),
    .dmi_resp_o       ( dmi_resp_o       ),
    .debug_req_o      ( debug_req_o      ),
    .ndmreset_o       ( ndmreset_o       ),
    .dmactive_o       ( dmactive_o       )
  );

  initial begin
    clk_i = 1'b0;
    forever #5 clk_i = ~clk_i;
  end

  //////////////////////////////////////////////////
  // Protocol properties
  //////////////////////////////////////////////////

  a_gnt_high: assert property (@(posedge clk_i) slave_gnt_o)
    else begin
      errors++;
      $display("ERROR @%0t: slave_gnt_o low", $time);
    end

  // Exactly one rvalid pulse on the cycle after each request
  a_rvalid_follows: assert property (@(posedge clk_i) disable iff (!rst_ni)
    slave_req_i |=> slave_rvalid_o)
    else begin
      errors++;
      $display("ERROR @%0t: missing rvalid after request", $time);
    end

  a_rvalid_only: assert property (@(posedge clk_i) disable iff (!rst_ni)
    !slave_req_i |=> !slave_rvalid_o)
    else begin
      errors++;
      $display("ERROR @%0t: rvalid without request", $time);
    end

  // Stalled response holds its payload
  a_resp_hold: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmi_resp_valid_o && !dmi_resp_ready_i |=> dmi_resp_valid_o && $stable(dmi_resp_o))
    else begin
      errors++;
      $display("ERROR @%0t: DMI response dropped or changed while stalled", $time);
    end

  a_req_blocked: assert property (@(posedge clk_i) disable iff (!rst_ni)
    dmi_resp_valid_o && !dmi_resp_ready_i |-> !dmi_req_ready_o)
    else begin
      errors++;
      $display("ERROR @%0t: dmi_req_ready_o high with response waiting", $time);
    end

  //////////////////////////////////////////////////
  // Monitors
  //////////////////////////////////////////////////

  always @(posedge clk_i) begin
    if (rst_ni && dmi_resp_valid_o && dmi_resp_ready_i) begin
      // Every handshake counts, expected or not
      dmi_received++;
      if (dmi_exp_q.size() == 0) begin
        errors++;
        $display("A DMI response arrived with no request outstanding at %0t", $time);
      end else begin
        dmi_exp = dmi_exp_q.pop_front();
        a_dmi_data: assert (dmi_resp_o.data == dmi_exp && dmi_resp_o.resp == 2'h0)
          else begin
            errors++;
            $display("ERROR @%0t: DMI data %h resp %0d, expected %h", $time,
                     dmi_resp_o.data, dmi_resp_o.resp, dmi_exp);
          end
      end
    end
  end

  always @(posedge clk_i) begin
    if (rst_ni && slave_rvalid_o) begin
      if (rid_exp_q.size() == 0) begin
        errors++;
        $display("An OBI response arrived with no request outstanding at %0t", $time);
      end else begin
        a_obi_resp: assert (slave_rid_o == rid_exp_q[0] && slave_rdata_o == rdata_exp_q[0])
          else begin
            errors++;
            $display("ERROR @%0t: OBI rid %h rdata %h, expected %h %h", $time,
                     slave_rid_o, slave_rdata_o, rid_exp_q[0], rdata_exp_q[0]);
          end
        void'(rid_exp_q.pop_front());
        void'(rdata_exp_q.pop_front());
      end
    end
  end

  // Response ready follows the stall mode
  always @(negedge clk_i) begin
    dmi_resp_ready_i <= stall_mode ? (($random(seed) & 3) == 0) : 1'b1;
  end

  always @(posedge clk_i) begin
    cycles++;
    if (cycles > MaxCycles) begin
      $display("Timeout: the run did not finish within %0d cycles", MaxCycles);
      $display("Result: FAILED");
      $finish;
    end
  end

  //////////////////////////////////////////////////
  // Driver tasks
  //////////////////////////////////////////////////

  // Leaves valid high so the next call can follow back to back
  task automatic dmi_issue(input logic [6:0] addr, input dm_ot::dmi_op_e op,
                           input logic [31:0] data, input logic [31:0] exp);
    @(negedge clk_i);
    dmi_req_valid_i = 1'b1;
    dmi_req_i.addr  = addr;
    dmi_req_i.op    = op;
    dmi_req_i.data  = data;
    do @(posedge clk_i); while (!dmi_req_ready_o);
    dmi_exp_q.push_back(exp);
    dmi_issued++;
  endtask

  task automatic dmi_drain();
    @(negedge clk_i);
    dmi_req_valid_i = 1'b0;
    while (dmi_exp_q.size() != 0) @(posedge clk_i);
    @(negedge clk_i);
  endtask

  task automatic dmi_write(input logic [6:0] addr, input logic [31:0] data);
    dmi_issue(addr, dm_ot::DmiWrite, data, 32'h0);
    dmi_drain();
  endtask

  task automatic dmi_read(input logic [6:0] addr, input logic [31:0] exp);
    dmi_issue(addr, dm_ot::DmiRead, 32'h0, exp);
    dmi_drain();
  endtask

  // One request per call; consecutive calls give back-to-back requests
  task automatic obi_access(input logic we, input logic [11:0] offset, input logic [3:0] be,
                            input logic [31:0] wdata, input logic [31:0] exp);
    @(negedge clk_i);
    slave_req_i   = 1'b1;
    slave_we_i    = we;
    slave_addr_i  = Base + {20'h0, offset};
    slave_be_i    = be;
    slave_wdata_i = wdata;
    slave_aid_i   = IdWidth'($random(seed));
    rid_exp_q.push_back(slave_aid_i);
    rdata_exp_q.push_back(we ? 32'h0 : exp);
  endtask

  task automatic obi_idle();
    @(negedge clk_i);
    slave_req_i = 1'b0;
    @(negedge clk_i);
    if (rid_exp_q.size() != 0) begin
      errors++;
      $display("OBI requests were left without a response at %0t", $time);
      rid_exp_q.delete();
      rdata_exp_q.delete();
    end
  endtask

  task automatic check_value(input string what, input logic [31:0] got,
                             input logic [31:0] exp);
    a_value: assert (got == exp)
      else begin
        errors++;
        $display("ERROR @%0t: %s is %h, expected %h", $time, what, got, exp);
      end
  endtask

  task automatic finish_test(input string name);
    tests_run++;
    if (errors == test_start_errors) begin
      $display("Test %0d %s: ok", tests_run, name);
    end else begin
      $display("Test %0d %s: %0d errors", tests_run, name, errors - test_start_errors);
    end
    test_start_errors = errors;
  endtask

  //////////////////////////////////////////////////
  // Tests
  //////////////////////////////////////////////////

  initial begin
    logic        nd;
    logic [3:0]  be;
    logic [31:0] wd;
    logic [31:0] merged;

    rst_ni           = 1'b0;
    slave_req_i      = 1'b0;
    slave_we_i       = 1'b0;
    slave_addr_i     = '0;
    slave_be_i       = '0;
    slave_wdata_i    = '0;
    slave_aid_i      = '0;
    dmi_req_valid_i  = 1'b0;
    dmi_req_i        = '0;
    dmi_resp_ready_i = 1'b1;
    repeat (8) @(posedge clk_i);
    @(negedge clk_i);
    rst_ni = 1'b1;
    check_value("dmi_resp_valid_o after reset", 32'(dmi_resp_valid_o), 0);
    check_value("dmi_req_ready_o after reset", 32'(dmi_req_ready_o), 1);
    check_value("slave_rvalid_o after reset", 32'(slave_rvalid_o), 0);
    check_value("debug_req_o after reset", 32'(debug_req_o), 0);
    check_value("ndmreset_o and dmactive_o after reset", 32'({ndmreset_o, dmactive_o}), 0);

    // Register write and read back
    nd        = 1'($random(seed));
    data0_val = $random(seed);
    prog0_val = $random(seed);
    prog1_val = $random(seed);
    dmi_write(dm_ot::DmControlAddr, {30'h0, nd, 1'b1});
    check_value("dmactive_o", 32'(dmactive_o), 1);
    check_value("ndmreset_o", 32'(ndmreset_o), 32'(nd));
    dmi_write(dm_ot::Data0Addr, data0_val);
    dmi_write(dm_ot::ProgBuf0Addr, prog0_val);
    dmi_write(dm_ot::ProgBuf1Addr, prog1_val);
    dmi_read(dm_ot::DmControlAddr, {30'h0, nd, 1'b1});
    dmi_read(dm_ot::Data0Addr, data0_val);
    dmi_read(dm_ot::ProgBuf0Addr, prog0_val);
    dmi_read(dm_ot::ProgBuf1Addr, prog1_val);
    // Version 2, authenticated, all running
    dmi_read(dm_ot::DmStatusAddr, 32'h0000_0c82);
    dmi_write(dm_ot::DmControlAddr, 32'h1);
    check_value("ndmreset_o", 32'(ndmreset_o), 0);
    finish_test("register access");

    // Halt handshake
    dmi_write(dm_ot::DmControlAddr, 32'h8000_0001);
    check_value("debug_req_o", 32'(debug_req_o), 1);
    obi_access(1'b0, dm_mem_pkg::FlagsOff, 4'hf, 32'h0, 32'h1);
    obi_access(1'b1, dm_mem_pkg::HaltedOff, 4'hf, 32'h0, 32'h0);
    obi_idle();
    check_value("debug_req_o after halted", 32'(debug_req_o), 0);
    dmi_read(dm_ot::DmStatusAddr, 32'h0000_0382);
    dmi_write(dm_ot::DmControlAddr, 32'h1);
    finish_test("halt");

    // Resume handshake
    dmi_write(dm_ot::DmControlAddr, 32'h4000_0001);
    obi_access(1'b0, dm_mem_pkg::FlagsOff, 4'hf, 32'h0, 32'h2);
    obi_access(1'b1, dm_mem_pkg::ResumingOff, 4'hf, 32'h0, 32'h0);
    obi_idle();
    dmi_read(dm_ot::DmStatusAddr, 32'h0003_0c82);
    obi_access(1'b0, dm_mem_pkg::FlagsOff, 4'hf, 32'h0, 32'h0);
    obi_idle();
    finish_test("resume");

    // Back-to-back hart accesses and a byte-merged data0 write
    be = 4'($random(seed));
    wd = $random(seed);
    for (int i = 0; i < 4; i++) begin
      merged[8*i +: 8] = be[i] ? wd[8*i +: 8] : data0_val[8*i +: 8];
    end
    obi_access(1'b0, dm_mem_pkg::ProgBufOff, 4'hf, 32'h0, prog0_val);
    obi_access(1'b0, dm_mem_pkg::ProgBufOff + 12'h4, 4'hf, 32'h0, prog1_val);
    obi_access(1'b0, dm_mem_pkg::Data0Off, 4'hf, 32'h0, data0_val);
    obi_access(1'b1, dm_mem_pkg::Data0Off, be, wd, 32'h0);
    obi_access(1'b0, dm_mem_pkg::Data0Off, 4'hf, 32'h0, merged);
    obi_access(1'b0, 12'h7fc, 4'hf, 32'h0, 32'h0);
    obi_idle();
    dmi_read(dm_ot::Data0Addr, merged);
    finish_test("hart window");

    // Response back-pressure with pipelined requests
    stall_mode = 1'b1;
    for (int i = 0; i < 8; i++) begin
      wd = $random(seed);
      dmi_issue(dm_ot::Data0Addr, dm_ot::DmiWrite, wd, 32'h0);
      dmi_issue(dm_ot::Data0Addr, dm_ot::DmiRead, 32'h0, wd);
    end
    dmi_drain();
    stall_mode = 1'b0;
    check_value("DMI responses received", dmi_received, dmi_issued);
    finish_test("back-pressure");

    $display("Tests run: %0d, errors: %0d", tests_run, errors);
    if (errors == 0) begin
      $display("Result: PASSED");
    end else begin
      $display("Result: FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: src/dm_dmi_regs.sv
// DMI front-end with a single response slot; a new request is taken only when that slot can drain
`timescale 1ns/1ps
`default_nettype none

module dm_dmi_regs (
  input  wire logic             clk_i,
  input  wire logic             rst_ni,
  // Debugger request channel
  input  wire logic             req_valid_i,
  output logic                  req_ready_o,
  input  wire dm_ot::dmi_req_t  req_i,
  // Debugger response channel
  output logic                  resp_valid_o,
  input  wire logic             resp_ready_i,
  output dm_ot::dmi_resp_t      resp_o,
  // Debug state and write operation toward it
  input  wire dm_ot::dm_state_t state_i,
  output dm_ot::dmi_wr_t        wr_o
);

  logic             resp_full_q;
  dm_ot::dmi_resp_t resp_q;
  logic             req_accept;
  logic             is_write;
  logic [31:0]      read_word;
  logic [31:0]      rdata_d;

  // Slot empty or draining this cycle
  assign req_ready_o = !resp_full_q || resp_ready_i;
  assign req_accept  = req_valid_i && req_ready_o;

  //////////////////////////////////////////////////
  // Read decode
  //////////////////////////////////////////////////

  always_comb begin
    read_word = '0;
    case (req_i.addr)
      dm_ot::DmStatusAddr: begin
        read_word[3:0]  = dm_ot::DmVersion;
        // No authentication scheme so always authenticated
        read_word[7]    = 1'b1;
        // One hart so any and all carry the same value
        read_word[8]    = state_i.halted;
        read_word[9]    = state_i.halted;
        read_word[10]   = !state_i.halted;
        read_word[11]   = !state_i.halted;
        read_word[16]   = state_i.resumeack;
        read_word[17]   = state_i.resumeack;
      end
      dm_ot::DmControlAddr: begin
        read_word[31] = state_i.haltreq;
        read_word[30] = state_i.resumereq;
        read_word[1]  = state_i.ndmreset;
        read_word[0]  = state_i.dmactive;
      end
      dm_ot::Data0Addr:    read_word = state_i.data0;
      dm_ot::ProgBuf0Addr: read_word = state_i.progbuf0;
      dm_ot::ProgBuf1Addr: read_word = state_i.progbuf1;
      // Unmapped addresses read zero
      default:             read_word = '0;
    endcase
  end

  // Writes and nops answer with zero data
  always_comb begin
    rdata_d  = '0;
    is_write = 1'b0;
    case (req_i.op)
      dm_ot::DmiRead:  rdata_d = read_word;
      dm_ot::DmiWrite: is_write = 1'b1;
      default:         rdata_d = '0;
    endcase
  end

  // Write lands in the state block on the accepting edge
  always_comb begin
    wr_o.valid = req_accept && is_write;
    wr_o.addr  = req_i.addr;
    wr_o.data  = req_i.data;
  end

  //////////////////////////////////////////////////
  // Response slot
  //////////////////////////////////////////////////

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      resp_full_q <= 1'b0;
    end else if (req_accept) begin
      resp_full_q <= 1'b1;
    end else if (resp_ready_i) begin
      resp_full_q <= 1'b0;
    end
  end

  // Payload only changes on acceptance so it holds while stalled
  always_ff @(posedge clk_i) begin
    if (req_accept) begin
      resp_q.data <= rdata_d;
      resp_q.resp <= dm_ot::DmiRespSuccess;
    end
  end

  assign resp_valid_o = resp_full_q;
  assign resp_o       = resp_q;

endmodule

`default_nettype wire

// File: src/dm_hart_port.sv
// Hart-side window decoder; never stalls, read data appears one cycle after the request
`timescale 1ns/1ps
`default_nettype none

module dm_hart_port (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // Granted request with offset already rebased
  input  wire logic                  valid_i,
  input  wire dm_mem_pkg::obi_req_t  req_i,
  // Debug state and hart events toward it
  input  wire dm_ot::dm_state_t      state_i,
  output dm_mem_pkg::hart_wr_t       wr_o,
  output logic [31:0]                rdata_o
);

  // Second program buffer word follows the first
  localparam logic [dm_mem_pkg::MemOffWidth-1:0] ProgBuf1Off =
    dm_mem_pkg::ProgBufOff + 12'h004;

  logic        wr_en;
  logic [31:0] read_word;
  logic [31:0] rdata_q;

  assign wr_en = valid_i && req_i.we;

  //////////////////////////////////////////////////
  // Write events
  //////////////////////////////////////////////////

  always_comb begin
    wr_o.set_halted   = wr_en && (req_i.offset == dm_mem_pkg::HaltedOff);
    wr_o.set_resuming = wr_en && (req_i.offset == dm_mem_pkg::ResumingOff);
    wr_o.wr_data0     = wr_en && (req_i.offset == dm_mem_pkg::Data0Off);
    // Byte merge happens in the state block
    wr_o.be           = req_i.be;
    wr_o.data         = req_i.wdata;
  end

  //////////////////////////////////////////////////
  // Read path
  //////////////////////////////////////////////////

  always_comb begin
    read_word = '0;
    case (req_i.offset)
      dm_mem_pkg::FlagsOff: begin
        // ROM polls these two bits to leave the park loop
        read_word[1] = state_i.resumereq;
        read_word[0] = state_i.haltreq;
      end
      dm_mem_pkg::Data0Off:   read_word = state_i.data0;
      dm_mem_pkg::ProgBufOff: read_word = state_i.progbuf0;
      ProgBuf1Off:            read_word = state_i.progbuf1;
      default:                read_word = '0;
    endcase
  end

  // Writes return zero on the response cycle
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rdata_q <= '0;
    end else if (valid_i) begin
      rdata_q <= req_i.we ? 32'h0 : read_word;
    end
  end

  assign rdata_o = rdata_q;

endmodule

`default_nettype wire

// File: src/dm_mem_pkg.sv
// Hart-side window map for one hart; offsets are relative to DmBaseAddress and 12 bits wide
`default_nettype none

package dm_mem_pkg;

  // Offset inside the debug memory window
  localparam int unsigned MemOffWidth = 12;

  //////////////////////////////////////////////////
  // Window offsets used by the debug ROM
  //////////////////////////////////////////////////

  // Hart reports entry into debug mode
  localparam logic [MemOffWidth-1:0] HaltedOff   = 12'h100;
  // Hart reports it is about to resume
  localparam logic [MemOffWidth-1:0] ResumingOff = 12'h108;
  // Flags word polled by the parked hart
  localparam logic [MemOffWidth-1:0] FlagsOff    = 12'h400;
  localparam logic [MemOffWidth-1:0] Data0Off    = 12'h380;
  // Two consecutive program buffer words start here
  localparam logic [MemOffWidth-1:0] ProgBufOff  = 12'h360;

  // Bus request after rebasing into the window
  typedef struct packed {
    logic                   we;
    logic [MemOffWidth-1:0] offset;
    logic [3:0]             be;
    logic [31:0]            wdata;
  } obi_req_t;

  // Hart-side write events into the state block
  typedef struct packed {
    logic        set_halted;
    logic        set_resuming;
    logic        wr_data0;
    logic [3:0]  be;
    logic [31:0] data;
  } hart_wr_t;

endpackage

`default_nettype wire

// File: src/dm_obi_top.sv
// OBI slave wrapper for the debug module; grant is always high and the hart cannot stall responses
`timescale 1ns/1ps
`default_nettype none

module dm_obi_top #(
  // Width of aid and rid
  parameter int unsigned IdWidth       = 1,
  parameter int unsigned DmBaseAddress = 'h1000
) (
  input  wire logic                clk_i,
  input  wire logic                rst_ni,
  // OBI slave port toward the hart
  input  wire logic                slave_req_i,
  output logic                     slave_gnt_o,
  input  wire logic                slave_we_i,
  input  wire logic [31:0]         slave_addr_i,
  input  wire logic [3:0]          slave_be_i,
  input  wire logic [31:0]         slave_wdata_i,
  input  wire logic [IdWidth-1:0]  slave_aid_i,
  output logic                     slave_rvalid_o,
  output logic [31:0]              slave_rdata_o,
  output logic [IdWidth-1:0]       slave_rid_o,
  // DMI port toward the debug transport
  input  wire logic                dmi_req_valid_i,
  output logic                     dmi_req_ready_o,
  input  wire dm_ot::dmi_req_t     dmi_req_i,
  output logic                     dmi_resp_valid_o,
  input  wire logic                dmi_resp_ready_i,
  output dm_ot::dmi_resp_t         dmi_resp_o,
  // Control outputs
  output logic                     debug_req_o,
  output logic                     ndmreset_o,
  output logic                     dmactive_o
);

  dm_mem_pkg::obi_req_t obi_req;
  logic                 obi_valid;
  logic                 rvalid_q;
  logic [IdWidth-1:0]   rid_q;

  // Core answers every request on the next cycle
  assign slave_gnt_o = 1'b1;
  assign obi_valid   = slave_req_i && slave_gnt_o;

  always_comb begin
    obi_req.we     = slave_we_i;
    // Low address bits; dm_top subtracts the base
    obi_req.offset = slave_addr_i[dm_mem_pkg::MemOffWidth-1:0];
    obi_req.be     = slave_be_i;
    obi_req.wdata  = slave_wdata_i;
  end

  dm_top #(
    .DmBaseAddress ( DmBaseAddress )
  ) i_dm_top (
    .clk_i            ( clk_i            ),
    .rst_ni           ( rst_ni           ),
    .obi_valid_i      ( obi_valid        ),
    .obi_req_i        ( obi_req          ),
    .obi_rdata_o      ( slave_rdata_o    ),
    .dmi_req_valid_i  ( dmi_req_valid_i  ),
    .dmi_req_ready_o  ( dmi_req_ready_o  ),
    .dmi_req_i        ( dmi_req_i        ),
    .dmi_resp_valid_o ( dmi_resp_valid_o ),
    .dmi_resp_ready_i ( dmi_resp_ready_i ),
    .dmi_resp_o       ( dmi_resp_o       ),
    .debug_req_o      ( debug_req_o      ),
    .ndmreset_o       ( ndmreset_o       ),
    .dmactive_o       ( dmactive_o       )
  );

  // One rvalid pulse per granted request with its id echoed
  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      rvalid_q <= 1'b0;
      rid_q    <= '0;
    end else begin
      rvalid_q <= obi_valid;
      if (obi_valid) begin
        rid_q <= slave_aid_i;
      end
    end
  end

  assign slave_rvalid_o = rvalid_q;
  assign slave_rid_o    = rid_q;

endmodule

`default_nettype wire

// File: src/dm_ot.sv
// Debug-spec types for a single-hart DM; no abstract commands, every DMI response reports success
`default_nettype none

package dm_ot;

  //////////////////////////////////////////////////
  // DMI transport
  //////////////////////////////////////////////////

  // DMI address width as seen by the debug transport module
  localparam int unsigned DmiAddrWidth = 7;

  // DMI request opcodes
  typedef enum logic [1:0] {
    DmiNop   = 2'h0,
    DmiRead  = 2'h1,
    DmiWrite = 2'h2
  } dmi_op_e;

  typedef struct packed {
    logic [DmiAddrWidth-1:0] addr;
    dmi_op_e                 op;
    logic [31:0]             data;
  } dmi_req_t;

  typedef struct packed {
    logic [31:0] data;
    logic [1:0]  resp;
  } dmi_resp_t;

  // Only success is ever returned
  localparam logic [1:0] DmiRespSuccess = 2'h0;

  //////////////////////////////////////////////////
  // Register map
  //////////////////////////////////////////////////

  localparam logic [DmiAddrWidth-1:0] Data0Addr     = 7'h04;
  localparam logic [DmiAddrWidth-1:0] DmControlAddr = 7'h10;
  localparam logic [DmiAddrWidth-1:0] DmStatusAddr  = 7'h11;
  localparam logic [DmiAddrWidth-1:0] ProgBuf0Addr  = 7'h20;
  localparam logic [DmiAddrWidth-1:0] ProgBuf1Addr  = 7'h21;

  // Debug spec 0.13 in dmstatus.version
  localparam logic [3:0] DmVersion = 4'd2;

  // Write operation from the DMI front-end into the state block
  typedef struct packed {
    logic                    valid;
    logic [DmiAddrWidth-1:0] addr;
    logic [31:0]             data;
  } dmi_wr_t;

  // Shared debug state for the one hart
  typedef struct packed {
    logic        dmactive;
    logic        ndmreset;
    logic        haltreq;
    logic        resumereq;
    logic        halted;
    logic        resumeack;
    logic [31:0] data0;
    logic [31:0] progbuf0;
    logic [31:0] progbuf1;
  } dm_state_t;

endpackage

`default_nettype wire

// File: src/dm_state.sv
// Shared debug state for one hart; DMI wins over the hart on a same-cycle data0 write
`timescale 1ns/1ps
`default_nettype none

module dm_state (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  input  wire dm_ot::dmi_wr_t        dmi_wr_i,
  input  wire dm_mem_pkg::hart_wr_t  hart_wr_i,
  output dm_ot::dm_state_t           state_o,
  output logic                       debug_req_o,
  output logic                       ndmreset_o,
  output logic                       dmactive_o
);

  dm_ot::dm_state_t state_d;
  dm_ot::dm_state_t state_q;

  always_comb begin
    state_d = state_q;

    //////////////////////////////////////////////////
    // Hart events first so DMI can override
    //////////////////////////////////////////////////

    if (hart_wr_i.set_halted) begin
      state_d.halted = 1'b1;
    end
    // Resuming ends the halt and acknowledges the request
    if (hart_wr_i.set_resuming) begin
      state_d.halted    = 1'b0;
      state_d.resumereq = 1'b0;
      state_d.resumeack = 1'b1;
    end
    if (hart_wr_i.wr_data0) begin
      for (int i = 0; i < 4; i++) begin
        if (hart_wr_i.be[i]) begin
          state_d.data0[8*i +: 8] = hart_wr_i.data[8*i +: 8];
        end
      end
    end

    //////////////////////////////////////////////////
    // Debugger writes
    //////////////////////////////////////////////////

    if (dmi_wr_i.valid) begin
      case (dmi_wr_i.addr)
        dm_ot::DmControlAddr: begin
          state_d.dmactive = dmi_wr_i.data[0];
          state_d.ndmreset = dmi_wr_i.data[1];
          state_d.haltreq  = dmi_wr_i.data[31];
          // resumereq is write-1 only
          if (dmi_wr_i.data[30]) begin
            state_d.resumereq = 1'b1;
            state_d.resumeack = 1'b0;
          end
        end
        dm_ot::Data0Addr:    state_d.data0    = dmi_wr_i.data;
        dm_ot::ProgBuf0Addr: state_d.progbuf0 = dmi_wr_i.data;
        dm_ot::ProgBuf1Addr: state_d.progbuf1 = dmi_wr_i.data;
        default: ;
      endcase
    end

    // Inactive module keeps everything at reset values
    if (!state_d.dmactive) begin
      state_d = '0;
    end
  end

  always_ff @(posedge clk_i or negedge rst_ni) begin
    if (!rst_ni) begin
      state_q <= '0;
    end else begin
      state_q <= state_d;
    end
  end

  assign state_o = state_q;

  // Request stays up until the hart reports halted
  assign debug_req_o = state_q.haltreq && !state_q.halted;
  assign ndmreset_o  = state_q.ndmreset;
  assign dmactive_o  = state_q.dmactive;

endmodule

`default_nettype wire

// File: src/dm_top.sv
// Core debug module for one hart; expects granted requests only and answers every one next cycle
`timescale 1ns/1ps
`default_nettype none

module dm_top #(
  // Start of the hart-side window
  parameter int unsigned DmBaseAddress = 'h1000
) (
  input  wire logic                  clk_i,
  input  wire logic                  rst_ni,
  // Hart side
  input  wire logic                  obi_valid_i,
  input  wire dm_mem_pkg::obi_req_t  obi_req_i,
  output logic [31:0]                obi_rdata_o,
  // Debugger side
  input  wire logic                  dmi_req_valid_i,
  output logic                       dmi_req_ready_o,
  input  wire dm_ot::dmi_req_t       dmi_req_i,
  output logic                       dmi_resp_valid_o,
  input  wire logic                  dmi_resp_ready_i,
  output dm_ot::dmi_resp_t           dmi_resp_o,
  // Hart and system control
  output logic                       debug_req_o,
  output logic                       ndmreset_o,
  output logic                       dmactive_o
);

  localparam int unsigned OffW = dm_mem_pkg::MemOffWidth;
  // Only the low bits of the base matter once the offset wraps
  localparam logic [OffW-1:0] BaseOff = OffW'(DmBaseAddress);

  dm_ot::dm_state_t     state;
  dm_ot::dmi_wr_t       dmi_wr;
  dm_mem_pkg::hart_wr_t hart_wr;
  dm_mem_pkg::obi_req_t hart_req;

  // Incoming offset carries low address bits; rebase into the window
  always_comb begin
    hart_req        = obi_req_i;
    hart_req.offset = obi_req_i.offset - BaseOff;
  end

  dm_dmi_regs i_dmi_regs (
    .clk_i        ( clk_i            ),
    .rst_ni       ( rst_ni           ),
    .req_valid_i  ( dmi_req_valid_i  ),
    .req_ready_o  ( dmi_req_ready_o  ),
    .req_i        ( dmi_req_i        ),
    .resp_valid_o ( dmi_resp_valid_o ),
    .resp_ready_i ( dmi_resp_ready_i ),
    .resp_o       ( dmi_resp_o       ),
    .state_i      ( state            ),
    .wr_o         ( dmi_wr           )
  );

  dm_hart_port i_hart_port (
    .clk_i   ( clk_i       ),
    .rst_ni  ( rst_ni      ),
    .valid_i ( obi_valid_i ),
    .req_i   ( hart_req    ),
    .state_i ( state       ),
    .wr_o    ( hart_wr     ),
    .rdata_o ( obi_rdata_o )
  );

  dm_state i_state (
    .clk_i       ( clk_i       ),
    .rst_ni      ( rst_ni      ),
    .dmi_wr_i    ( dmi_wr      ),
    .hart_wr_i   ( hart_wr     ),
    .state_o     ( state       ),
    .debug_req_o ( debug_req_o ),
    .ndmreset_o  ( ndmreset_o  ),
    .dmactive_o  ( dmactive_o  )
  );

endmodule

`default_nettype wire
